// ==== testbench/periph_vectors.txt ====
// op (1 write, 2 read, 0 end), address, byte enable, write data, expected read, mask
// RAM at 06010000, counter at 06040000, GPIO at 06048000
1 06010000 F 11223344 00000000 00000000
1 06010001 F CAFEF00D 00000000 00000000
2 06010000 F 00000000 11223344 FFFFFFFF
2 06010001 F 00000000 CAFEF00D FFFFFFFF
1 06010205 F 5A5A0F0F 00000000 00000000
2 06010005 F 00000000 5A5A0F0F FFFFFFFF
1 06040001 F 00001234 00000000 00000000
2 06040001 F 00000000 00001234 FFFFFFFF
2 06040000 F 00000000 00000000 FFFFFFFF
2 06040003 F 00000000 00000000 FFFFFFFF
1 06048000 3 FFFFF321 00000000 00000000
2 06048000 F 00000000 00000321 FFFFFFFF
2 06048001 F 00000000 00000000 FFFFFFFF
2 06040007 F 00000000 00000000 FFFFFFFF
// Writes to unmapped slaves and to other regions
1 06028000 F DEADBEEF 00000000 00000000
1 06028001 F DEADBEEF 00000000 00000000
1 08010000 F DEADBEEF 00000000 00000000
1 08040001 F DEADBEEF 00000000 00000000
1 00048000 F DEADBEEF 00000000 00000000
2 06028000 F 00000000 00000000 FFFFFFFF
2 08010000 F 00000000 00000000 FFFFFFFF
2 00048000 F 00000000 00000000 FFFFFFFF
// Mapped contents unchanged
2 06010000 F 00000000 11223344 FFFFFFFF
2 06040001 F 00000000 00001234 FFFFFFFF
2 06048000 F 00000000 00000321 FFFFFFFF
0 00000000 0 00000000 00000000 00000000

// ==== all.f ====
logic/SocPkg.sv
logic/BusDecoder.sv
logic/DataRam.sv
logic/CycleCounter.sv
logic/SegmentGpio.sv
logic/PeriphSubsystem.sv
testbench/tb_PeriphSubsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the peripheral subsystem testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert -f all.f --top-module tb_PeriphSubsystem \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== testbench/tb_PeriphSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_PeriphSubsystem
    import SocPkg::*;
();

    localparam int c_ScanDiv    = 4;
    localparam int c_MaxVectors = 32;
    localparam int c_SweepWords = 16;
    localparam int c_SweepOps   = 3 * c_SweepWords;

    localparam logic [c_AddrBits-1:0] c_RamBase     = {c_PeriphRegion, SLAVE_RAM, 15'd0};
    localparam logic [c_AddrBits-1:0] c_CounterBase = {c_PeriphRegion, SLAVE_COUNTER, 15'd0};
    localparam logic [c_AddrBits-1:0] c_GpioBase    = {c_PeriphRegion, SLAVE_GPIO, 15'd0};

    // Hex digit patterns, segments gfedcba
    localparam logic [6:0] c_SegTable [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    typedef enum logic [31:0] {
        OP_END   = 32'd0,
        OP_WRITE = 32'd1,
        OP_READ  = 32'd2
    } vecOp_t;

    logic                  w_SysClk;
    logic                  i_rstN;
    logic [c_AddrBits-1:0] i_Address;
    logic [3:0]            i_ByteEn;
    logic                  i_Read;
    logic                  i_Write;
    logic [31:0]           i_WriteData;
    wire  [31:0]           o_ReadData;
    wire                   o_WaitRequest;
    wire  [2:0]            o_7Seg_En;
    wire  [6:0]            o_7Seg_Led;

    logic [31:0] vecMem [6*c_MaxVectors];
    logic [31:0] lfsrState;
    int          errorCount;
    int          testCount;
    int          failedTests;
    int          testErrorBase;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    string       testName;

    PeriphSubsystem #(
        .RamDepth(512),
        .ScanDiv(c_ScanDiv)
    ) i_dut (
        .w_SysClk(w_SysClk),
        .i_rstN(i_rstN),
        .i_Address(i_Address),
        .i_ByteEn(i_ByteEn),
        .i_Read(i_Read),
        .i_Write(i_Write),
        .i_WriteData(i_WriteData),
        .o_ReadData(o_ReadData),
        .o_WaitRequest(o_WaitRequest),
        .o_7Seg_En(o_7Seg_En),
        .o_7Seg_Led(o_7Seg_Led)
    );

    initial w_SysClk = 1'b0;
    always #4 w_SysClk = ~w_SysClk;

    always @(posedge w_SysClk) begin
        cycleCount++;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // One step per bit taken
    function automatic logic [31:0] takeRandomBits(input int count);
        logic [31:0] value;
        logic        outBit;
        value = 32'd0;
        for (int i = 0; i < count; i++) begin
            outBit    = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (outBit)
                lfsrState = lfsrState ^ 32'h80200003;
            value = {value[30:0], outBit};
        end
        return value;
    endfunction

    function automatic logic [31:0] byteMask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    // Only a RAM read inserts a wait state
    function automatic int expectedWaits(input logic [c_AddrBits-1:0] addr);
        logic [c_RegionBits-1:0] region;
        logic [c_SlaveBits-1:0]  slave;
        region = addr[c_AddrBits-1 -: c_RegionBits];
        slave  = addr[c_AddrBits-c_RegionBits-1 -: c_SlaveBits];
        return (region == c_PeriphRegion && slave == SLAVE_RAM) ? 1 : 0;
    endfunction

    task automatic startTest(input string name);
        testName      = name;
        testErrorBase = errorCount;
    endtask

    task automatic finishTest();
        testCount++;
        if (errorCount == testErrorBase) begin
            $display("test %s: ok", testName);
        end else begin
            failedTests++;
            $display("test %s: failed with %0d errors", testName, errorCount - testErrorBase);
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] actual,
                             input logic [31:0] expected, input logic [31:0] mask);
        if ((actual & mask) !== (expected & mask)) begin
            errorCount++;
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic checkSegment(input string name, input logic [6:0] actual,
                                input logic [6:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // Called 1 ns after a rising edge, returns at the same point
    task automatic busWrite(input logic [c_AddrBits-1:0] addr, input logic [3:0] be,
                            input logic [31:0] data, output int waits);
        waits       = 0;
        i_Address   = addr;
        i_ByteEn    = be;
        i_WriteData = data;
        i_Write     = 1'b1;
        @(negedge w_SysClk);
        while (o_WaitRequest) begin
            waits++;
            @(negedge w_SysClk);
        end
        @(posedge w_SysClk);
        #1;
        i_Write = 1'b0;
    endtask

    task automatic busRead(input logic [c_AddrBits-1:0] addr, output logic [31:0] data,
                           output int waits);
        waits     = 0;
        i_Address = addr;
        i_ByteEn  = 4'hF;
        i_Read    = 1'b1;
        @(negedge w_SysClk);
        while (o_WaitRequest) begin
            waits++;
            @(negedge w_SysClk);
        end
        data = o_ReadData;
        @(posedge w_SysClk);
        #1;
        i_Read = 1'b0;
    endtask

    task automatic replayVector(input int index);
        logic [31:0]           op;
        logic [c_AddrBits-1:0] addr;
        logic [31:0]           readData;
        int                    waits;
        op   = vecMem[6*index];
        addr = vecMem[6*index+1][c_AddrBits-1:0];
        if (op == OP_WRITE) begin
            busWrite(addr, vecMem[6*index+2][3:0], vecMem[6*index+3], waits);
            checkWord($sformatf("o_WaitRequest cycles (vector %0d)", index), 32'(waits), 0, '1);
        end else if (op == OP_READ) begin
            busRead(addr, readData, waits);
            checkWord($sformatf("o_ReadData (vector %0d)", index), readData,
                      vecMem[6*index+4], vecMem[6*index+5]);
            checkWord($sformatf("o_WaitRequest cycles (vector %0d)", index), 32'(waits),
                      32'(expectedWaits(addr)), '1);
        end else begin
            errorCount++;
            $display("vector %0d has an unknown operation code %h", index, op);
        end
    endtask

    // Counts the falling edges until the enable selects the position
    task automatic waitForDigit(input int pos, output int waited);
        waited = 1;
        @(negedge w_SysClk);
        while (o_7Seg_En !== (3'b001 << pos)) begin
            waited++;
            @(negedge w_SysClk);
        end
    endtask

    initial begin
        int          vecCount;
        int          waits;
        int          polls;
        logic [31:0] readData;
        logic [31:0] firstValue;
        logic [31:0] secondValue;
        logic [31:0] data;
        logic [3:0]  be;
        logic [11:0] digits;
        logic [31:0] ramModel [c_SweepWords];

        i_rstN      = 1'b0;
        i_Address   = '0;
        i_ByteEn    = 4'h0;
        i_Read      = 1'b0;
        i_Write     = 1'b0;
        i_WriteData = 32'd0;
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        lfsrState   = 32'd82;

        for (int i = 0; i < 6*c_MaxVectors; i++)
            vecMem[i] = 32'd0;
        $readmemh("testbench/periph_vectors.txt", vecMem);
        vecCount = 0;
        while (vecCount < c_MaxVectors && vecMem[6*vecCount] != OP_END)
            vecCount++;
        if (vecCount == 0) begin
            errorCount++;
            $display("no vectors were read from the vector file");
        end
        cycleLimit = 8 * (vecCount + c_SweepOps) + 200;

        repeat (3) @(posedge w_SysClk);
        #1;
        i_rstN = 1'b1;

        startTest("reset state");
        @(negedge w_SysClk);
        checkWord("o_ReadData", o_ReadData, 32'd0, '1);
        checkWord("o_WaitRequest", 32'(o_WaitRequest), 32'd0, '1);
        @(posedge w_SysClk);
        #1;
        finishTest();

        startTest("vector replay");
        for (int v = 0; v < vecCount; v++)
            replayVector(v);
        finishTest();

        startTest("ram sweep");
        for (int i = 0; i < c_SweepWords; i++) begin
            data        = takeRandomBits(32);
            ramModel[i] = data;
            busWrite(c_RamBase + c_AddrBits'(64 + i), 4'hF, data, waits);
            checkWord("o_WaitRequest cycles", 32'(waits), 32'd0, '1);
        end
        // Partial writes merge into the model word
        for (int i = 0; i < c_SweepWords; i++) begin
            be          = 4'(takeRandomBits(4));
            data        = takeRandomBits(32);
            ramModel[i] = (ramModel[i] & ~byteMask(be)) | (data & byteMask(be));
            busWrite(c_RamBase + c_AddrBits'(64 + i), be, data, waits);
        end
        for (int i = 0; i < c_SweepWords; i++) begin
            busRead(c_RamBase + c_AddrBits'(64 + i), readData, waits);
            checkWord("o_ReadData", readData, ramModel[i], '1);
            checkWord("o_WaitRequest cycles", 32'(waits), 32'd1, '1);
        end
        finishTest();

        startTest("counter advance");
        busWrite(c_CounterBase + c_AddrBits'(REG_CTRL), 4'hF, 32'd1, waits);
        busRead(c_CounterBase + c_AddrBits'(REG_VALUE), firstValue, waits);
        busRead(c_CounterBase + c_AddrBits'(REG_VALUE), secondValue, waits);
        if (secondValue <= firstValue) begin
            errorCount++;
            $display("counter did not advance: first read %h, second read %h",
                     firstValue, secondValue);
        end
        finishTest();

        startTest("counter match");
        busRead(c_CounterBase + c_AddrBits'(REG_VALUE), firstValue, waits);
        busWrite(c_CounterBase + c_AddrBits'(REG_COMPARE), 4'hF, firstValue + 32'd16, waits);
        busRead(c_CounterBase + c_AddrBits'(REG_STATUS), readData, waits);
        checkWord("o_ReadData", readData, 32'd0, '1);
        polls = 0;
        while (readData[0] !== 1'b1 && polls < 40) begin
            busRead(c_CounterBase + c_AddrBits'(REG_STATUS), readData, waits);
            polls++;
        end
        checkWord("o_ReadData", readData, 32'd1, '1);
        busWrite(c_CounterBase + c_AddrBits'(REG_STATUS), 4'h1, 32'd1, waits);
        busRead(c_CounterBase + c_AddrBits'(REG_STATUS), readData, waits);
        checkWord("o_ReadData", readData, 32'd0, '1);
        finishTest();

        startTest("gpio scan");
        digits = 12'(takeRandomBits(12));
        busWrite(c_GpioBase, 4'h3, {20'hFFFFF, digits}, waits);
        busRead(c_GpioBase, readData, waits);
        checkWord("o_ReadData", readData, {20'd0, digits}, '1);
        for (int pos = 0; pos < 3; pos++) begin
            waitForDigit(pos, polls);
            // The next position follows within one scan period
            if (pos > 0 && polls > c_ScanDiv) begin
                errorCount++;
                $display("digit enable took %0d cycles to step to position %0d",
                         polls, pos);
            end
            checkSegment("o_7Seg_Led", o_7Seg_Led, c_SegTable[digits[4*pos +: 4]]);
        end
        @(posedge w_SysClk);
        #1;
        finishTest();

        $display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/PeriphSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module PeriphSubsystem
    import SocPkg::*;
#(
    parameter int RamDepth = 512,
    parameter int ScanDiv  = 16
) (
    input  wire                    w_SysClk,
    input  wire                    i_rstN,
    input  wire [c_AddrBits-1:0]   i_Address,
    input  wire [3:0]              i_ByteEn,
    input  wire                    i_Read,
    input  wire                    i_Write,
    input  wire [31:0]             i_WriteData,
    output wire [31:0]             o_ReadData,
    output wire                    o_WaitRequest,
    output wire [2:0]              o_7Seg_En,
    output wire [6:0]              o_7Seg_Led
);

    wire                 w_RamSel;
    wire                 w_CounterSel;
    wire                 w_GpioSel;
    wire [c_RegBits-1:0] w_RegAddr;

    wire [31:0] w_RamReadData;
    wire        w_RamWait;
    wire [31:0] w_CounterReadData;
    wire        w_CounterWait;
    wire [31:0] w_GpioReadData;
    wire        w_GpioWait;

    BusDecoder Decoder0 (
        .w_SysClk(w_SysClk),
        .i_rstN(i_rstN),
        .i_Address(i_Address),
        .i_RamReadData(w_RamReadData),
        .i_RamWait(w_RamWait),
        .i_CounterReadData(w_CounterReadData),
        .i_CounterWait(w_CounterWait),
        .i_GpioReadData(w_GpioReadData),
        .i_GpioWait(w_GpioWait),
        .o_RamSel(w_RamSel),
        .o_CounterSel(w_CounterSel),
        .o_GpioSel(w_GpioSel),
        .o_RegAddr(w_RegAddr),
        .o_ReadData(o_ReadData),
        .o_WaitRequest(o_WaitRequest)
    );

    DataRam #(
        .RamDepth(RamDepth)
    ) Ram0 (
        .w_SysClk(w_SysClk),
        .i_rstN(i_rstN),
        .i_Sel(w_RamSel),
        .i_RegAddr(w_RegAddr),
        .i_ByteEn(i_ByteEn),
        .i_Read(i_Read),
        .i_Write(i_Write),
        .i_WriteData(i_WriteData),
        .o_ReadData(w_RamReadData),
        .o_WaitRequest(w_RamWait)
    );

    CycleCounter Counter0 (
        .w_SysClk(w_SysClk),
        .i_rstN(i_rstN),
        .i_Sel(w_CounterSel),
        .i_RegAddr(w_RegAddr),
        .i_ByteEn(i_ByteEn),
        .i_Read(i_Read),
        .i_Write(i_Write),
        .i_WriteData(i_WriteData),
        .o_ReadData(w_CounterReadData),
        .o_WaitRequest(w_CounterWait)
    );

    SegmentGpio #(
        .ScanDiv(ScanDiv)
    ) Gpio0 (
        .w_SysClk(w_SysClk),
        .i_rstN(i_rstN),
        .i_Sel(w_GpioSel),
        .i_RegAddr(w_RegAddr),
        .i_ByteEn(i_ByteEn),
        .i_Read(i_Read),
        .i_Write(i_Write),
        .i_WriteData(i_WriteData),
        .o_ReadData(w_GpioReadData),
        .o_WaitRequest(w_GpioWait),
        .o_7Seg_En(o_7Seg_En),
        .o_7Seg_Led(o_7Seg_Led)
    );

endmodule

`default_nettype wire

// ==== logic/SegmentGpio.sv ====
`timescale 1ns/1ps
`default_nettype none

module SegmentGpio
    import SocPkg::*;
#(
    parameter int ScanDiv = 16
) (
    input  wire                    w_SysClk,
    input  wire                    i_rstN,
    input  wire                    i_Sel,
    input  wire [c_RegBits-1:0]    i_RegAddr,
    input  wire [3:0]              i_ByteEn,
    input  wire                    i_Read,
    input  wire                    i_Write,
    input  wire [31:0]             i_WriteData,
    output logic [31:0]            o_ReadData,
    output logic                   o_WaitRequest,
    output logic [2:0]             o_7Seg_En,
    output logic [6:0]             o_7Seg_Led
);

    localparam int c_DivBits = (ScanDiv > 1) ? $clog2(ScanDiv) : 1;

    logic [11:0]          r_Digits;
    logic [c_DivBits-1:0] r_Prescale;
    logic [1:0]           r_ScanPos;
    logic [3:0]           w_Digit;

    wire        w_RegHit     = i_Sel && (i_RegAddr == '0);
    wire [31:0] w_DigitsNext = f_MergeBytes({20'd0, r_Digits}, i_WriteData, i_ByteEn);

    // Segments gfedcba, bit 0 is a
    function automatic logic [6:0] f_HexToSeg(input logic [3:0] hex);
        case (hex)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    always_ff @(posedge w_SysClk) begin
        if (!i_rstN) begin
            r_Digits   <= 12'd0;
            r_Prescale <= '0;
            r_ScanPos  <= 2'd0;
            o_7Seg_En  <= 3'b001;
        end else begin
            if (w_RegHit && i_Write)
                r_Digits <= w_DigitsNext[11:0];
            if (r_Prescale == c_DivBits'(ScanDiv - 1)) begin
                r_Prescale <= '0;
                r_ScanPos  <= (r_ScanPos == 2'd2) ? 2'd0 : r_ScanPos + 2'd1;
            end else begin
                r_Prescale <= r_Prescale + 1'b1;
            end
            o_7Seg_En <= 3'b001 << r_ScanPos;
        end
    end

    always_comb begin
        case (r_ScanPos)
            2'd1:    w_Digit = r_Digits[7:4];
            2'd2:    w_Digit = r_Digits[11:8];
            default: w_Digit = r_Digits[3:0];
        endcase
    end

    // Follows the scan position one cycle later, like the enables
    always_ff @(posedge w_SysClk) begin
        o_7Seg_Led <= f_HexToSeg(w_Digit);
    end

    assign o_ReadData    = (w_RegHit && i_Read) ? {20'd0, r_Digits} : 32'd0;
    assign o_WaitRequest = 1'b0;

    a_EnOneHot: assert property (
        @(posedge w_SysClk) disable iff (!i_rstN)
        $onehot(o_7Seg_En)
    ) else $error("SegmentGpio: digit enable not one-hot");

endmodule

`default_nettype wire

// ==== logic/CycleCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module CycleCounter
    import SocPkg::*;
(
    input  wire                    w_SysClk,
    input  wire                    i_rstN,
    input  wire                    i_Sel,
    input  wire [c_RegBits-1:0]    i_RegAddr,
    input  wire [3:0]              i_ByteEn,
    input  wire                    i_Read,
    input  wire                    i_Write,
    input  wire [31:0]             i_WriteData,
    output logic [31:0]            o_ReadData,
    output logic                   o_WaitRequest
);

    logic        r_Enable;
    logic [31:0] r_Value;
    logic [31:0] r_Compare;
    logic        r_Match;

    wire        w_Write       = i_Sel && i_Write;
    wire [31:0] w_ValueNext   = f_MergeBytes(r_Value, i_WriteData, i_ByteEn);
    wire [31:0] w_CompareNext = f_MergeBytes(r_Compare, i_WriteData, i_ByteEn);
    wire        w_ClearMatch  = w_Write && (i_RegAddr == REG_STATUS)
                                && i_ByteEn[0] && i_WriteData[0];

    always_ff @(posedge w_SysClk) begin
        if (!i_rstN) begin
            r_Enable  <= 1'b0;
            r_Value   <= 32'd0;
            r_Compare <= 32'd0;
            r_Match   <= 1'b0;
        end else begin
            // Bus load wins over counting
            if (w_Write && i_RegAddr == REG_VALUE)
                r_Value <= w_ValueNext;
            else if (r_Enable)
                r_Value <= r_Value + 32'd1;
            if (w_Write && i_RegAddr == REG_COMPARE)
                r_Compare <= w_CompareNext;
            if (w_Write && i_RegAddr == REG_CTRL && i_ByteEn[0])
                r_Enable <= i_WriteData[0];
            if (r_Enable && r_Value == r_Compare)
                r_Match <= 1'b1;
            else if (w_ClearMatch)
                r_Match <= 1'b0;
        end
    end

    always_comb begin
        o_ReadData = 32'd0;
        if (i_Sel && i_Read) begin
            case (i_RegAddr)
                REG_CTRL:    o_ReadData = {31'd0, r_Enable};
                REG_VALUE:   o_ReadData = r_Value;
                REG_COMPARE: o_ReadData = r_Compare;
                REG_STATUS:  o_ReadData = {31'd0, r_Match};
                default:     o_ReadData = 32'd0;
            endcase
        end
    end

    assign o_WaitRequest = 1'b0;

endmodule

`default_nettype wire

// ==== logic/DataRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module DataRam
    import SocPkg::*;
#(
    parameter int RamDepth = 512
) (
    input  wire                    w_SysClk,
    input  wire                    i_rstN,
    input  wire                    i_Sel,
    input  wire [c_RegBits-1:0]    i_RegAddr,
    input  wire [3:0]              i_ByteEn,
    input  wire                    i_Read,
    input  wire                    i_Write,
    input  wire [31:0]             i_WriteData,
    output logic [31:0]            o_ReadData,
    output logic                   o_WaitRequest
);

    localparam int c_IndexBits = $clog2(RamDepth);

    logic [31:0] r_Mem [RamDepth];
    logic [31:0] r_ReadWord;
    ramState_t   r_State;

    wire [c_IndexBits-1:0] w_Index   = i_RegAddr[c_IndexBits-1:0];
    wire                   w_ReadReq = i_Sel && i_Read;

    always_ff @(posedge w_SysClk) begin
        if (i_Sel && i_Write) begin
            for (int b = 0; b < 4; b++) begin
                if (i_ByteEn[b])
                    r_Mem[w_Index][b*8 +: 8] <= i_WriteData[b*8 +: 8];
            end
        end
        // Capture during the wait cycle
        if (w_ReadReq && r_State == RAM_IDLE)
            r_ReadWord <= r_Mem[w_Index];
    end

    always_ff @(posedge w_SysClk) begin
        if (!i_rstN) begin
            r_State <= RAM_IDLE;
        end else begin
            case (r_State)
                RAM_IDLE: if (w_ReadReq) r_State <= RAM_READ;
                default:  r_State <= RAM_IDLE;
            endcase
        end
    end

    assign o_WaitRequest = w_ReadReq && (r_State == RAM_IDLE);
    assign o_ReadData    = (w_ReadReq && r_State == RAM_READ) ? r_ReadWord : 32'd0;

    // Master never asks for both at once
    a_NoReadWrite: assert property (
        @(posedge w_SysClk) disable iff (!i_rstN)
        i_Sel |-> !(i_Read && i_Write)
    ) else $error("DataRam: read and write in the same cycle");

endmodule

`default_nettype wire

// ==== logic/BusDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module BusDecoder
    import SocPkg::*;
(
    input  wire                    w_SysClk,
    input  wire                    i_rstN,
    input  wire [c_AddrBits-1:0]   i_Address,

    input  wire [31:0]             i_RamReadData,
    input  wire                    i_RamWait,
    input  wire [31:0]             i_CounterReadData,
    input  wire                    i_CounterWait,
    input  wire [31:0]             i_GpioReadData,
    input  wire                    i_GpioWait,

    output logic                   o_RamSel,
    output logic                   o_CounterSel,
    output logic                   o_GpioSel,
    output logic [c_RegBits-1:0]   o_RegAddr,
    output logic [31:0]            o_ReadData,
    output logic                   o_WaitRequest
);

    wire [c_RegionBits-1:0] w_RegionField = i_Address[c_AddrBits-1 -: c_RegionBits];
    wire [c_SlaveBits-1:0]  w_SlaveField  = i_Address[c_RegBits +: c_SlaveBits];
    wire                    w_InRegion    = (w_RegionField == c_PeriphRegion);

    assign o_RamSel     = w_InRegion && (w_SlaveField == SLAVE_RAM);
    assign o_CounterSel = w_InRegion && (w_SlaveField == SLAVE_COUNTER);
    assign o_GpioSel    = w_InRegion && (w_SlaveField == SLAVE_GPIO);
    assign o_RegAddr    = i_Address[c_RegBits-1:0];

    // Unselected slaves return zero, so a plain OR merges the bus
    assign o_ReadData    = i_RamReadData | i_CounterReadData | i_GpioReadData;
    assign o_WaitRequest = i_RamWait | i_CounterWait | i_GpioWait;

    a_QuietSlaves: assert property (
        @(posedge w_SysClk) disable iff (!i_rstN)
        (o_RamSel || (i_RamReadData == 32'd0 && !i_RamWait))
        && (o_CounterSel || (i_CounterReadData == 32'd0 && !i_CounterWait))
        && (o_GpioSel || (i_GpioReadData == 32'd0 && !i_GpioWait))
    ) else $error("BusDecoder: unselected slave drives the bus");

endmodule

`default_nettype wire

// ==== logic/SocPkg.sv ====
`default_nettype none

package SocPkg;

    // Word address split, region field on top
    localparam int c_AddrBits   = 30;
    localparam int c_RegionBits = 5;
    localparam int c_SlaveBits  = 10;
    localparam int c_RegBits    = c_AddrBits - c_RegionBits - c_SlaveBits;

    localparam logic [c_RegionBits-1:0] c_PeriphRegion = 5'd3;

    typedef enum logic [c_SlaveBits-1:0] {
        SLAVE_RAM     = 10'd2,
        SLAVE_COUNTER = 10'd8,
        SLAVE_GPIO    = 10'd9
    } slaveId_t;

    typedef enum logic {
        RAM_IDLE,
        RAM_READ
    } ramState_t;

    typedef enum logic [c_RegBits-1:0] {
        REG_CTRL    = 15'd0,
        REG_VALUE   = 15'd1,
        REG_COMPARE = 15'd2,
        REG_STATUS  = 15'd3
    } counterReg_t;

    // Replace only the bytes whose enable is set
    function automatic logic [31:0] f_MergeBytes(
        input logic [31:0] oldWord,
        input logic [31:0] newWord,
        input logic [3:0]  byteEn
    );
        logic [31:0] merged;
        merged = oldWord;
        for (int b = 0; b < 4; b++) begin
            if (byteEn[b])
                merged[b*8 +: 8] = newWord[b*8 +: 8];
        end
        return merged;
    endfunction

endpackage

`default_nettype wire
